// ==== hw/des_pkg.sv ====
package des_pkg;

	// ##########################################################
	// widths and counts
	// ##########################################################

	localparam int BLOCK_W    = 64;
	localparam int HALF_W     = 32;
	localparam int KEY_HALF_W = 28;
	localparam int SUBKEY_W   = 48;
	localparam int NUM_ROUNDS = 16;

	typedef logic [3:0] round_t;

	typedef enum logic {
		DES_ENCRYPT = 1'b0,
		DES_DECRYPT = 1'b1
	} des_op_e;

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_ROUND = 2'd1,
		ST_DONE  = 2'd2
	} des_state_e;

	// ##########################################################
	// permutation tables
	// ##########################################################

	// each entry names the source bit, counted from the MSB starting at zero.
	// this is the standard's 1-based table with one subtracted from every entry.
	typedef logic [5:0] tbl_idx_t;
	typedef logic [1:0] shift_t;

	localparam tbl_idx_t IP_TABLE [64] = '{
		57, 49, 41, 33, 25, 17,  9,  1,
		59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5,
		63, 55, 47, 39, 31, 23, 15,  7,
		56, 48, 40, 32, 24, 16,  8,  0,
		58, 50, 42, 34, 26, 18, 10,  2,
		60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6
	};

	localparam tbl_idx_t FP_TABLE [64] = '{
		39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30,
		37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28,
		35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26,
		33,  1, 41,  9, 49, 17, 57, 25,
		32,  0, 40,  8, 48, 16, 56, 24
	};

	// expansion of R, one row per S-box group.
	localparam tbl_idx_t E_TABLE [48] = '{
		31,  0,  1,  2,  3,  4,
		 3,  4,  5,  6,  7,  8,
		 7,  8,  9, 10, 11, 12,
		11, 12, 13, 14, 15, 16,
		15, 16, 17, 18, 19, 20,
		19, 20, 21, 22, 23, 24,
		23, 24, 25, 26, 27, 28,
		27, 28, 29, 30, 31,  0
	};

	localparam tbl_idx_t P_TABLE [32] = '{
		15,  6, 19, 20, 28, 11, 27, 16,
		 0, 14, 22, 25,  4, 17, 30,  9,
		 1,  7, 23, 13, 31, 26,  2,  8,
		18, 12, 29,  5, 21, 10,  3, 24
	};

	// the first four rows build C and the last four build D.
	localparam tbl_idx_t PC1_TABLE [56] = '{
		56, 48, 40, 32, 24, 16,  8,
		 0, 57, 49, 41, 33, 25, 17,
		 9,  1, 58, 50, 42, 34, 26,
		18, 10,  2, 59, 51, 43, 35,
		62, 54, 46, 38, 30, 22, 14,
		 6, 61, 53, 45, 37, 29, 21,
		13,  5, 60, 52, 44, 36, 28,
		20, 12,  4, 27, 19, 11,  3
	};

	localparam tbl_idx_t PC2_TABLE [48] = '{
		13, 16, 10, 23,  0,  4,
		 2, 27, 14,  5, 20,  9,
		22, 18, 11,  3, 25,  7,
		15,  6, 26, 19, 12,  1,
		40, 51, 30, 36, 46, 54,
		29, 39, 50, 44, 32, 47,
		43, 48, 38, 55, 33, 52,
		45, 41, 49, 35, 28, 31
	};

	// left rotation applied before each encryption round.
	localparam shift_t SHIFT_TABLE [16] = '{
		1, 1, 2, 2, 2, 2, 2, 2,
		1, 2, 2, 2, 2, 2, 2, 1
	};

endpackage

// ==== hw/des_sbox.sv ====
`timescale 1ns/1ns

module des_sbox import des_pkg::*; (
	input  logic [SUBKEY_W-1:0] i_bits,
	output logic [HALF_W-1:0]   o_bits
);

	// one table per box, 64 entries each, addressed by {row, column}.
	localparam logic [3:0] SBOX [8][64] = '{
		'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		   0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		   4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		  15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
		'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		   3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		   0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		  13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
		'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		  13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		  13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		   1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
		'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		  13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		  10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		   3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
		'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		  14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		   4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		  11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
		'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		  10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		   9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		   4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
		'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		  13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		   1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		   6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
		'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		   1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		   7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		   2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
	};

	// group 0 is the top six bits and feeds S1, whose result lands on top.
	for (genvar g = 0; g < 8; g++) begin : g_box
		logic [5:0] grp;
		logic [1:0] row;
		logic [3:0] col;

		assign grp = i_bits[SUBKEY_W-1-6*g -: 6];
		assign row = {grp[5], grp[0]};
		assign col = grp[4:1];
		assign o_bits[HALF_W-1-4*g -: 4] = SBOX[g][{row, col}];
	end

endmodule

// ==== hw/des_round_func.sv ====
`timescale 1ns/1ns

module des_round_func import des_pkg::*; (
	input  logic [HALF_W-1:0]   i_r,
	input  logic [SUBKEY_W-1:0] i_subkey,
	output logic [HALF_W-1:0]   o_f
);

	logic [SUBKEY_W-1:0] expanded;
	logic [SUBKEY_W-1:0] mixed;
	logic [HALF_W-1:0]   sbox_out;

	// expansion duplicates the edge bits of each nibble into its neighbours.
	for (genvar i = 0; i < SUBKEY_W; i++) begin : g_expand
		assign expanded[SUBKEY_W-1-i] = i_r[HALF_W-1-E_TABLE[i]];
	end

	assign mixed = expanded ^ i_subkey;

	des_sbox i_des_sbox (
		.i_bits (mixed),
		.o_bits (sbox_out)
	);

	for (genvar i = 0; i < HALF_W; i++) begin : g_perm
		assign o_f[HALF_W-1-i] = sbox_out[HALF_W-1-P_TABLE[i]];
	end

endmodule

// ==== hw/des_key_schedule.sv ====
`timescale 1ns/1ns

module des_key_schedule import des_pkg::*; (
	input  logic                i_Clk,
	input  logic                i_Rst,
	input  logic                i_load,
	input  logic                i_advance,
	input  des_op_e             i_op,
	input  round_t              i_round,
	input  logic [BLOCK_W-1:0]  i_key,
	output logic [SUBKEY_W-1:0] o_subkey
);

	logic [2*KEY_HALF_W-1:0] pc1_key;
	logic [2*KEY_HALF_W-1:0] cd;
	logic [KEY_HALF_W-1:0]   c_q;
	logic [KEY_HALF_W-1:0]   d_q;
	round_t                  fwd_idx;
	round_t                  rev_idx;
	shift_t                  step;

	// left for encryption, right for decryption, by one or two places.
	function automatic logic [KEY_HALF_W-1:0] rotate(
		input logic [KEY_HALF_W-1:0] v,
		input shift_t                amt,
		input des_op_e               op
	);
		if (op == DES_ENCRYPT) begin
			return (amt == 2'd2) ? {v[KEY_HALF_W-3:0], v[KEY_HALF_W-1 -: 2]}
			                     : {v[KEY_HALF_W-2:0], v[KEY_HALF_W-1]};
		end
		return (amt == 2'd2) ? {v[1:0], v[KEY_HALF_W-1:2]}
		                     : {v[0], v[KEY_HALF_W-1:1]};
	endfunction

	for (genvar i = 0; i < 2*KEY_HALF_W; i++) begin : g_pc1
		assign pc1_key[2*KEY_HALF_W-1-i] = i_key[BLOCK_W-1-PC1_TABLE[i]];
	end

	// the registers already hold the halves for the round in progress, so the
	// step prepares the next round. encryption looks one entry ahead, while
	// decryption walks the table backwards from its last entry.
	assign fwd_idx = i_round + 4'd1;
	assign rev_idx = 4'd15 - i_round;
	assign step    = (i_op == DES_ENCRYPT) ? SHIFT_TABLE[fwd_idx] : SHIFT_TABLE[rev_idx];

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			c_q <= '0;
			d_q <= '0;
		end else if (i_load) begin
			if (i_op == DES_ENCRYPT) begin
				c_q <= rotate(pc1_key[2*KEY_HALF_W-1:KEY_HALF_W], SHIFT_TABLE[0], DES_ENCRYPT);
				d_q <= rotate(pc1_key[KEY_HALF_W-1:0], SHIFT_TABLE[0], DES_ENCRYPT);
			end else begin
				// C0/D0 equal C16/D16, so decryption starts on K16 directly.
				c_q <= pc1_key[2*KEY_HALF_W-1:KEY_HALF_W];
				d_q <= pc1_key[KEY_HALF_W-1:0];
			end
		end else if (i_advance) begin
			c_q <= rotate(c_q, step, i_op);
			d_q <= rotate(d_q, step, i_op);
		end
	end

	assign cd = {c_q, d_q};

	for (genvar i = 0; i < SUBKEY_W; i++) begin : g_pc2
		assign o_subkey[SUBKEY_W-1-i] = cd[2*KEY_HALF_W-1-PC2_TABLE[i]];
	end

endmodule

// ==== hw/des_core.sv ====
`timescale 1ns/1ns

module des_core import des_pkg::*; (
	input  logic               i_Clk,
	input  logic               i_Rst,
	input  logic               i_start,
	input  des_op_e            i_op,
	input  logic [BLOCK_W-1:0] i_key,
	input  logic [BLOCK_W-1:0] i_text,
	output logic               o_ready,
	output logic               o_done,
	output logic [BLOCK_W-1:0] o_text
);

	des_state_e          state_q;
	round_t              round_q;
	des_op_e             op_q;
	des_op_e             key_op;
	logic                accept;
	logic                in_round;
	logic [HALF_W-1:0]   l_q;
	logic [HALF_W-1:0]   r_q;
	logic [HALF_W-1:0]   f_out;
	logic [BLOCK_W-1:0]  ip_out;
	logic [BLOCK_W-1:0]  fp_in;
	logic [SUBKEY_W-1:0] subkey;

	// ##########################################################
	// handshake
	// ##########################################################

	assign o_ready  = (state_q == ST_IDLE);
	assign o_done   = (state_q == ST_DONE);
	assign accept   = i_start && o_ready;
	assign in_round = (state_q == ST_ROUND);

	// the key schedule loads on the acceptance edge, before op_q holds the
	// new operation, so it sees the input directly while idle.
	assign key_op = o_ready ? i_op : op_q;

	// ##########################################################
	// datapath
	// ##########################################################

	for (genvar i = 0; i < BLOCK_W; i++) begin : g_ip
		assign ip_out[BLOCK_W-1-i] = i_text[BLOCK_W-1-IP_TABLE[i]];
	end

	des_key_schedule i_des_key_schedule (
		.i_Clk     (i_Clk),
		.i_Rst     (i_Rst),
		.i_load    (accept),
		.i_advance (in_round),
		.i_op      (key_op),
		.i_round   (round_q),
		.i_key     (i_key),
		.o_subkey  (subkey)
	);

	des_round_func i_des_round_func (
		.i_r      (r_q),
		.i_subkey (subkey),
		.o_f      (f_out)
	);

	// the halves are swapped here to undo the swap of the last round.
	assign fp_in = {r_q, l_q};

	for (genvar i = 0; i < BLOCK_W; i++) begin : g_fp
		assign o_text[BLOCK_W-1-i] = fp_in[BLOCK_W-1-FP_TABLE[i]];
	end

	// ##########################################################
	// control
	// ##########################################################

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			state_q <= ST_IDLE;
			round_q <= '0;
			op_q    <= DES_ENCRYPT;
			l_q     <= '0;
			r_q     <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_start) begin
						state_q <= ST_ROUND;
						round_q <= '0;
						op_q    <= i_op;
						l_q     <= ip_out[BLOCK_W-1:HALF_W];
						r_q     <= ip_out[HALF_W-1:0];
					end
				end
				ST_ROUND: begin
					l_q     <= r_q;
					r_q     <= l_q ^ f_out;
					round_q <= round_q + 4'd1;
					// round_q wraps back to zero here, ready for the next block.
					if (round_q == round_t'(NUM_ROUNDS - 1)) begin
						state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					state_q <= ST_IDLE;
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verif/des_sva.sv ====
`timescale 1ns/1ns

module des_sva (
	input logic i_Clk,
	input logic i_Rst,
	input logic i_start,
	input logic o_ready,
	input logic o_done
);

	logic accept;

	assign accept = i_start && o_ready;

	a_done_single: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		o_done |=> !o_done)
		else $error("o_done was high on two cycles in a row");

	// o_ready stays low through the done cycle and comes back on the next edge.
	a_ready_after_done: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		o_done |-> !o_ready ##1 o_ready)
		else $error("o_ready was high with o_done or did not return after it");

	// o_done rises after the sixteenth edge and is first sampled one edge later.
	a_done_latency: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		$past(accept, 17) |-> o_done)
		else $error("o_done did not follow an accepted start after sixteen rounds");

endmodule

bind des_core des_sva i_des_sva (
	.i_Clk   (i_Clk),
	.i_Rst   (i_Rst),
	.i_start (i_start),
	.o_ready (o_ready),
	.o_done  (o_done)
);

// ==== verif/des_model.svh ====
`ifndef DES_MODEL_SVH
`define DES_MODEL_SVH

// ############################################################
// DES reference tables, 1-based as printed in the standard
// ############################################################

localparam int INIT_PERM [64] = '{
	58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
	62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
	57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
	61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
};

localparam int FINAL_PERM [64] = '{
	40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
	38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
	36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
	34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
};

localparam int EXPANSION [48] = '{
	32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13,
	12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
	24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
};

localparam int ROUND_PERM [32] = '{
	16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
	2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
};

localparam int KEY_PERM1 [56] = '{
	57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
	10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
	63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
	14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
};

localparam int KEY_PERM2 [48] = '{
	14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4, 26, 8,
	16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
	44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
};

localparam int KEY_SHIFTS [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

// each box holds its four rows of sixteen nibbles, row 0 first.
localparam logic [255:0] SBOXES [8] = '{
	256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
	256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
	256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
	256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
	256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
	256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
	256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
	256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
};

// all sixteen subkeys come from left rotations, and decryption uses them reversed.
function automatic logic [63:0] des_reference(
	input logic [63:0] key,
	input logic [63:0] text,
	input bit          decrypt
);
	logic [55:0] cd;
	logic [27:0] c;
	logic [27:0] d;
	logic [47:0] subkeys [16];
	logic [47:0] x;
	logic [5:0]  addr;
	logic [31:0] s;
	logic [31:0] f;
	logic [31:0] l;
	logic [31:0] r;
	logic [31:0] tmp;
	logic [63:0] blk;
	logic [63:0] result;
	int          i;
	int          k;
	int          n;
	int          b;

	for (i = 0; i < 56; i++) begin
		cd[55-i] = key[64-KEY_PERM1[i]];
	end
	c = cd[55:28];
	d = cd[27:0];
	for (k = 0; k < 16; k++) begin
		for (n = 0; n < KEY_SHIFTS[k]; n++) begin
			c = {c[26:0], c[27]};
			d = {d[26:0], d[27]};
		end
		cd = {c, d};
		for (i = 0; i < 48; i++) begin
			subkeys[k][47-i] = cd[56-KEY_PERM2[i]];
		end
	end

	for (i = 0; i < 64; i++) begin
		blk[63-i] = text[64-INIT_PERM[i]];
	end
	l = blk[63:32];
	r = blk[31:0];
	for (k = 0; k < 16; k++) begin
		for (i = 0; i < 48; i++) begin
			x[47-i] = r[32-EXPANSION[i]];
		end
		x = x ^ (decrypt ? subkeys[15-k] : subkeys[k]);
		for (b = 0; b < 8; b++) begin
			addr = {x[47-6*b], x[42-6*b], x[46-6*b -: 4]};
			s[31-4*b -: 4] = SBOXES[b][255-4*addr -: 4];
		end
		for (i = 0; i < 32; i++) begin
			f[31-i] = s[32-ROUND_PERM[i]];
		end
		tmp = r;
		r = l ^ f;
		l = tmp;
	end

	blk = {r, l};
	for (i = 0; i < 64; i++) begin
		result[63-i] = blk[64-FINAL_PERM[i]];
	end
	return result;
endfunction

`endif

// ==== verif/des_tb.sv ====
`timescale 1ns/1ns

module des_tb import des_pkg::*; ();

	localparam int          TIMEOUT_CYCLES = 40;
	localparam int          NUM_RANDOM     = 200;
	localparam logic [63:0] KAT_KEY        = 64'h133457799BBCDFF1;
	localparam logic [63:0] KAT_PLAIN      = 64'h0123456789ABCDEF;
	localparam logic [63:0] KAT_CIPHER     = 64'h85E813540F0AB405;

	logic        i_Clk;
	logic        i_Rst;
	logic        i_start;
	des_op_e     i_op;
	logic [63:0] i_key;
	logic [63:0] i_text;
	logic        o_ready;
	logic        o_done;
	logic [63:0] o_text;
	int          errors;
	int          checks;
	int          done_count;
	bit          timed_out;
	logic [31:0] lcg_state;

	`include "des_model.svh"

	des_core i_des_core (
		.i_Clk   (i_Clk),
		.i_Rst   (i_Rst),
		.i_start (i_start),
		.i_op    (i_op),
		.i_key   (i_key),
		.i_text  (i_text),
		.o_ready (o_ready),
		.o_done  (o_done),
		.o_text  (o_text)
	);

	always #50 i_Clk = ~i_Clk;

	always @(negedge i_Clk) begin
		if (i_Rst && o_done) begin
			done_count <= done_count + 1;
		end
	end

	// ############################################################
	// helpers
	// ############################################################

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic next_cycle();
		@(posedge i_Clk);
		#5;
	endtask

	task automatic end_run();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (o_ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			next_cycle();
			cycles++;
		end
		if (o_ready !== 1'b1) begin
			$display("timed out waiting for o_ready");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	// the poke raises i_start while the core is busy, with other data on the inputs.
	task automatic run_block(
		input  logic [63:0] key,
		input  logic [63:0] text,
		input  des_op_e     op,
		input  bit          poke,
		output logic [63:0] result
	);
		int edges;
		int prev_count;
		result = '0;
		if (!timed_out) begin
			wait_ready();
		end
		if (timed_out) begin
			return;
		end
		prev_count = done_count;
		i_start = 1'b1;
		i_key = key;
		i_text = text;
		i_op = op;
		next_cycle();
		i_start = 1'b0;
		i_key = ~key;
		i_text = ~text;
		i_op = (op == DES_ENCRYPT) ? DES_DECRYPT : DES_ENCRYPT;
		edges = 0;
		while (o_done !== 1'b1 && edges < TIMEOUT_CYCLES) begin
			checks++;
			if (o_ready !== 1'b0) begin
				errors++;
				$display("Fail o_ready: got %h, expected %h", o_ready, 1'b0);
			end
			if (poke) begin
				i_start = (edges == 4);
			end
			next_cycle();
			edges++;
		end
		if (o_done !== 1'b1) begin
			$display("timed out waiting for o_done");
			errors++;
			timed_out = 1'b1;
			return;
		end
		checks++;
		if (edges != 16) begin
			errors++;
			$display("Fail done_edge: got %h, expected %h", edges, 16);
		end
		checks++;
		if (o_ready !== 1'b0) begin
			errors++;
			$display("Fail o_ready: got %h, expected %h", o_ready, 1'b0);
		end
		result = o_text;
		i_start = 1'b0;
		next_cycle();
		checks++;
		if (o_done !== 1'b0) begin
			errors++;
			$display("Fail o_done: got %h, expected %h", o_done, 1'b0);
		end
		checks++;
		if (o_ready !== 1'b1) begin
			errors++;
			$display("Fail o_ready: got %h, expected %h", o_ready, 1'b1);
		end
		checks++;
		if (done_count != prev_count + 1) begin
			errors++;
			$display("Fail done_count: got %h, expected %h", done_count, prev_count + 1);
		end
	endtask

	// ############################################################
	// stimulus
	// ############################################################

	initial begin
		logic [63:0] key;
		logic [63:0] text;
		logic [63:0] expected;
		logic [63:0] result;
		logic [63:0] back;
		logic [31:0] r;
		des_op_e     op;

		i_Clk = 1'b0;
		i_Rst = 1'b0;
		i_start = 1'b0;
		i_op = DES_ENCRYPT;
		i_key = '0;
		i_text = '0;
		errors = 0;
		checks = 0;
		done_count = 0;
		timed_out = 1'b0;
		lcg_state = 32'hdfeafb72;

		repeat (8) @(posedge i_Clk);
		#5;
		i_Rst = 1'b1;
		next_cycle();
		checks++;
		if (o_ready !== 1'b1) begin
			errors++;
			$display("Fail o_ready: got %h, expected %h", o_ready, 1'b1);
		end
		checks++;
		if (o_done !== 1'b0) begin
			errors++;
			$display("Fail o_done: got %h, expected %h", o_done, 1'b0);
		end

		// the model itself must reproduce the published example.
		checks++;
		if (des_reference(KAT_KEY, KAT_PLAIN, 1'b0) !== KAT_CIPHER) begin
			errors++;
			$display("the reference model does not reproduce the known answer");
		end
		run_block(KAT_KEY, KAT_PLAIN, DES_ENCRYPT, 1'b0, result);
		checks++;
		if (!timed_out && result !== KAT_CIPHER) begin
			errors++;
			$display("Fail o_text: got %h, expected %h", result, KAT_CIPHER);
		end
		run_block(KAT_KEY, KAT_CIPHER, DES_DECRYPT, 1'b1, result);
		checks++;
		if (!timed_out && result !== KAT_PLAIN) begin
			errors++;
			$display("Fail o_text: got %h, expected %h", result, KAT_PLAIN);
		end

		for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
			key = {next_random(), next_random()};
			text = {next_random(), next_random()};
			r = next_random();
			op = des_op_e'(r[31]);
			expected = des_reference(key, text, op == DES_DECRYPT);
			run_block(key, text, op, r[29], result);
			checks++;
			if (!timed_out && result !== expected) begin
				errors++;
				$display("Fail o_text: got %h, expected %h", result, expected);
			end
			run_block(key, result, (op == DES_ENCRYPT) ? DES_DECRYPT : DES_ENCRYPT, 1'b0, back);
			checks++;
			if (!timed_out && back !== text) begin
				errors++;
				$display("Fail o_text: got %h, expected %h", back, text);
			end
		end

		end_run();
	end

endmodule

// ==== vlog.f ====
+incdir+verif
hw/des_pkg.sv
hw/des_sbox.sv
hw/des_round_func.sv
hw/des_key_schedule.sv
hw/des_core.sv
verif/des_sva.sv
verif/des_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= des_tb
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
